/* src/ring_bus_config.svh */
`ifndef RING_BUS_CONFIG_SVH
`define RING_BUS_CONFIG_SVH

// cycles from a request on the line to the first bus clock edge, minus one
`define RING_START_CYCLES 12

// message fields, address goes out first
`define RING_ADDR_BITS 4
`define RING_DATA_BITS 8

// member nodes on the ring
`define RING_MEMBERS 2

`endif

/* src/ring_bus_msg_pkg.sv */
`default_nettype none

`include "ring_bus_config.svh"

package ring_bus_msg_pkg;

	// shifted out msb first, addr then data
	typedef struct packed
	{
		logic [`RING_ADDR_BITS-1:0] addr;
		logic [`RING_DATA_BITS-1:0] data;
	} ring_msg_t;

	// host to member
	typedef struct packed
	{
		logic req;
		ring_msg_t msg;
	} ring_tx_t;

	// member to host, single cycle
	typedef struct packed
	{
		logic valid;
		ring_msg_t msg;
	} ring_rx_t;

endpackage

`default_nettype wire

/* src/ring_bus_line_pkg.sv */
`default_nettype none

package ring_bus_line_pkg;

	// one hop of the ring
	typedef struct packed
	{
		logic clk;
		logic data;
	} ring_line_t;

	// fast bit phases first, then the slow control sequence
	typedef enum logic [4:0]
	{
		ST_IDLE,
		ST_WAIT_START,
		ST_ARB_LO,
		ST_ARB_HI,
		ST_DRIVE_HI,
		ST_DRIVE_LO,
		ST_LATCH_HI,
		ST_LATCH_LO,
		ST_S0_LO,
		ST_S0_HI,
		ST_S1_LO,
		ST_S1_HI,
		ST_S0A_LO,
		ST_S0A_HI,
		ST_REL_LO,
		ST_REL_HI,
		ST_BTI_LO,
		ST_BTI_HI
	} ring_ctrl_state_e;

endpackage

`default_nettype wire

/* src/ring_bus_ctrl.sv */
`default_nettype none

`include "ring_bus_config.svh"

module ring_bus_ctrl
	import ring_bus_line_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input ring_line_t line_in,
	output ring_line_t line_out
);

	localparam int CNT_BITS = $clog2(`RING_START_CYCLES);

	ring_ctrl_state_e state, next_state;
	logic bus_clk, next_clk;
	logic hold, next_hold;
	logic dout, next_dout;
	logic half, next_half;
	logic lat, next_lat;
	logic [CNT_BITS-1:0] start_cnt, next_cnt;
	logic [3:0] hist;
	logic irq;
	logic sample_en;
	logic in_ctrl;

	// low half of the same control bit
	function automatic ring_ctrl_state_e lo_half(input ring_ctrl_state_e s);
		ring_ctrl_state_e r;
		case (s)
			ST_S0_HI: r = ST_S0_LO;
			ST_S1_HI: r = ST_S1_LO;
			ST_S0A_HI: r = ST_S0A_LO;
			ST_REL_HI: r = ST_REL_LO;
			default: r = ST_BTI_LO;
		endcase
		return r;
	endfunction

	assign line_out.clk = bus_clk;
	assign line_out.data = hold ? dout : line_in.data;

	assign in_ctrl = (state >= ST_S0_LO);

	// sender toggled twice inside one bit
	assign irq = (state == ST_DRIVE_LO) && (hist[0] ^ line_in.data);

	always_comb
	begin
		case (state)
			ST_ARB_LO, ST_DRIVE_LO, ST_LATCH_LO: sample_en = 1'b1;
			ST_S0_LO, ST_S1_LO, ST_S0A_LO, ST_REL_LO, ST_BTI_LO: sample_en = half;
			default: sample_en = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= ST_IDLE;
			bus_clk <= 1'b1;
			hold <= 1'b1;
			dout <= 1'b1;
			half <= 1'b0;
			lat <= 1'b0;
			start_cnt <= CNT_BITS'(`RING_START_CYCLES - 1);
			hist <= '0;
		end
		else
		begin
			state <= next_state;
			bus_clk <= next_clk;
			hold <= next_hold;
			dout <= next_dout;
			half <= next_half;
			lat <= next_lat;
			start_cnt <= next_cnt;
			if (sample_en)
				hist <= {hist[2:0], line_in.data};
		end
	end

	always_comb
	begin
		next_state = state;
		next_clk = bus_clk;
		next_hold = hold;
		next_dout = dout;
		next_half = half;
		next_lat = lat;
		next_cnt = start_cnt;

		case (state)
			ST_IDLE:
			begin
				next_cnt = CNT_BITS'(`RING_START_CYCLES - 1);
				next_half = 1'b0;
				next_lat = 1'b0;
				if (!line_in.data)
					next_state = ST_WAIT_START;
			end

			ST_WAIT_START:
			begin
				if (start_cnt != '0)
					next_cnt = start_cnt - 1'b1;
				else
				begin
					next_state = ST_ARB_LO;
					next_clk = 1'b0;
				end
			end

			ST_ARB_LO:
			begin
				next_state = ST_ARB_HI;
				next_clk = 1'b1;
			end

			// open the ring for the winner
			ST_ARB_HI:
			begin
				next_state = ST_DRIVE_LO;
				next_clk = 1'b0;
				next_hold = 1'b0;
			end

			ST_DRIVE_HI:
			begin
				next_state = ST_DRIVE_LO;
				next_clk = 1'b0;
			end

			ST_DRIVE_LO:
			begin
				if (irq)
				begin
					next_state = ST_S0_LO;
					next_hold = 1'b1;
					next_dout = 1'b0;
				end
				else
				begin
					next_state = ST_LATCH_HI;
					next_clk = 1'b1;
				end
			end

			ST_LATCH_HI:
			begin
				next_state = ST_LATCH_LO;
				next_clk = 1'b0;
			end

			ST_LATCH_LO:
			begin
				next_state = ST_DRIVE_HI;
				next_clk = 1'b1;
			end

			ST_S0_LO, ST_S1_LO, ST_S0A_LO, ST_REL_LO, ST_BTI_LO:
			begin
				next_half = ~half;
				if (half)
				begin
					next_state = ring_ctrl_state_e'(state + 1'b1);
					next_clk = 1'b1;
				end
			end

			default:
			begin
				next_half = ~half;
				if (half)
				begin
					next_clk = 1'b0;
					if (!lat)
					begin
						// latch pair of the same bit
						next_lat = 1'b1;
						next_state = lo_half(state);
					end
					else
					begin
						next_lat = 1'b0;
						next_state = ST_S0_LO;
						next_dout = 1'b0;
						case (state)
							ST_S0_HI:
							begin
								if (!hist[0])
								begin
									next_state = ST_S1_LO;
									next_dout = 1'b1;
								end
							end
							ST_S1_HI:
							begin
								if (hist[0])
									next_state = ST_S0A_LO;
							end
							ST_S0A_HI:
							begin
								if (!hist[0])
								begin
									next_state = ST_REL_LO;
									next_dout = 1'b1;
								end
							end
							ST_REL_HI:
							begin
								next_state = ST_BTI_LO;
								next_dout = 1'b1;
							end
							default:
							begin
								next_state = ST_IDLE;
								next_dout = 1'b1;
								next_clk = 1'b1;
							end
						endcase
					end
				end
			end
		endcase
	end

	a_idle_clk_high: assert property (@(posedge CLK) disable iff (!RESET)
		(state == ST_IDLE) |-> line_out.clk);

	a_hold_in_ctrl: assert property (@(posedge CLK) disable iff (!RESET)
		in_ctrl |-> hold);

endmodule

`default_nettype wire

/* src/ring_bus_member.sv */
`default_nettype none

`include "ring_bus_config.svh"

module ring_bus_member
	import ring_bus_msg_pkg::*, ring_bus_line_pkg::*;
#(
	parameter logic [`RING_ADDR_BITS-1:0] NODE_ID = 1
)
(
	input logic CLK,
	input logic RESET,
	input ring_line_t line_in,
	output ring_line_t line_out,
	input ring_tx_t tx,
	output logic tx_ack,
	output ring_rx_t rx
);

	localparam int MSG_BITS = $bits(ring_msg_t);
	localparam int IDX_BITS = $clog2(MSG_BITS + 3);

	logic clk_q;
	logic fwd_q;
	logic bus_edge;
	logic active, arb_done, ctrl_seen, won;
	logic [1:0] ph;
	logic [1:0] quiet;
	logic drv_en, drv_bit;
	logic [IDX_BITS-1:0] tx_idx, rx_cnt;
	logic [MSG_BITS-1:0] tx_bits;
	ring_msg_t rx_sr;
	logic fast_edge, drive_ev, sample_ev, latch_lo_ev, bus_done;

	assign line_out.clk = line_in.clk;
	assign line_out.data = drv_en ? drv_bit : fwd_q;

	assign tx_bits = tx.msg;
	assign bus_edge = line_in.clk ^ clk_q;

	// edges after arbitration cycle drive-lo, latch-hi, latch-lo, drive-hi
	assign fast_edge = active && arb_done && !ctrl_seen && bus_edge;
	assign drive_ev = fast_edge && (ph == 2'd0);
	assign sample_ev = fast_edge && (ph == 2'd1);
	assign latch_lo_ev = fast_edge && (ph == 2'd2);

	// clock steady for longer than any control half means idle again
	assign bus_done = ctrl_seen && (quiet == 2'd3);

	always_ff @(posedge CLK)
	begin
		if (sample_ev)
			rx_sr <= ring_msg_t'({rx_sr[MSG_BITS-2:0], line_in.data});
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			clk_q <= 1'b1;
			fwd_q <= 1'b1;
			quiet <= '0;
			active <= 1'b0;
			arb_done <= 1'b0;
			ctrl_seen <= 1'b0;
			won <= 1'b0;
			ph <= '0;
			drv_en <= 1'b0;
			drv_bit <= 1'b1;
			tx_idx <= '0;
			rx_cnt <= '0;
			tx_ack <= 1'b0;
			rx <= '0;
		end
		else
		begin
			clk_q <= line_in.clk;
			fwd_q <= line_in.data;
			rx.valid <= 1'b0;
			if (bus_edge)
				quiet <= '0;
			else if (quiet != 2'd3)
				quiet <= quiet + 1'b1;
			if (tx_ack && !tx.req)
				tx_ack <= 1'b0;

			if (!active)
			begin
				// pull the idle line low to request
				drv_en <= tx.req && !tx_ack;
				drv_bit <= 1'b0;
				if (bus_edge)
					active <= 1'b1;
			end
			else if (ctrl_seen)
			begin
				if (bus_done)
				begin
					active <= 1'b0;
					arb_done <= 1'b0;
					ctrl_seen <= 1'b0;
					won <= 1'b0;
					tx_idx <= '0;
					rx_cnt <= '0;
					if (won)
						tx_ack <= 1'b1;
					else if (rx_cnt == IDX_BITS'(MSG_BITS) && rx_sr.addr == NODE_ID)
					begin
						rx.valid <= 1'b1;
						rx.msg <= rx_sr;
					end
				end
			end
			else if (!bus_edge)
			begin
				// slow clock, controller owns the line
				ctrl_seen <= 1'b1;
				drv_en <= 1'b0;
			end
			else if (!arb_done)
			begin
				// still high upstream means nobody ahead of us wants it
				arb_done <= 1'b1;
				ph <= '0;
				won <= drv_en && line_in.data;
				drv_en <= drv_en && line_in.data;
			end
			else
			begin
				ph <= ph + 1'b1;
				if (sample_ev && rx_cnt <= IDX_BITS'(MSG_BITS))
					rx_cnt <= rx_cnt + 1'b1;
				if (won && drive_ev)
				begin
					if (tx_idx < IDX_BITS'(MSG_BITS))
					begin
						drv_bit <= tx_bits[IDX_BITS'(MSG_BITS - 1) - tx_idx];
						tx_idx <= tx_idx + 1'b1;
					end
					else if (tx_idx == IDX_BITS'(MSG_BITS + 1))
					begin
						drv_bit <= ~drv_bit;
						tx_idx <= tx_idx + 1'b1;
					end
				end
				// first half of the end toggle
				if (won && latch_lo_ev && tx_idx == IDX_BITS'(MSG_BITS))
				begin
					drv_bit <= ~drv_bit;
					tx_idx <= tx_idx + 1'b1;
				end
			end
		end
	end

	a_ack_falls_after_req: assert property (@(posedge CLK) disable iff (!RESET)
		$fell(tx_ack) |-> $past(!tx.req));

endmodule

`default_nettype wire

/* src/ring_bus_top.sv */
`default_nettype none

`include "ring_bus_config.svh"

module ring_bus_top
	import ring_bus_msg_pkg::*, ring_bus_line_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input ring_tx_t tx [`RING_MEMBERS],
	output logic tx_ack [`RING_MEMBERS],
	output ring_rx_t rx [`RING_MEMBERS]
);

	// hop 0 leaves the controller, the last hop returns to it
	ring_line_t hop [`RING_MEMBERS+1];

	ring_bus_ctrl ctrl_inst
	(
		.CLK(CLK),
		.RESET(RESET),
		.line_in(hop[`RING_MEMBERS]),
		.line_out(hop[0])
	);

	for (genvar i = 0; i < `RING_MEMBERS; i++)
	begin : g_member
		ring_bus_member #(
			.NODE_ID(`RING_ADDR_BITS'(i + 1))
		) member_inst
		(
			.CLK(CLK),
			.RESET(RESET),
			.line_in(hop[i]),
			.line_out(hop[i+1]),
			.tx(tx[i]),
			.tx_ack(tx_ack[i]),
			.rx(rx[i])
		);
	end

endmodule

`default_nettype wire

/* testbench/ring_bus_checker.sv */
`default_nettype none

`include "ring_bus_config.svh"

module ring_bus_checker
	import ring_bus_msg_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input ring_tx_t tx [`RING_MEMBERS],
	input logic tx_ack [`RING_MEMBERS],
	input ring_rx_t rx [`RING_MEMBERS],
	output logic done,
	output int pass_count,
	output int fail_count,
	output int error_count
);

	localparam int MAX_LINES = 16;
	localparam int COLS = 6;

	logic [7:0] words [0:MAX_LINES*COLS-1];

	// one entry per message on the bus, in the order the bus carries them
	int exp_sender [$];
	int exp_rx [$];
	ring_msg_t exp_msg [$];
	bit exp_last [$];

	logic ack_q [`RING_MEMBERS];
	bit rx_seen;
	bit trans_bad;
	int trans_idx;

	// member whose node id matches, -1 when nobody answers
	function automatic int member_for(input logic [`RING_ADDR_BITS-1:0] addr);
		int m;
		m = -1;
		for (int i = 0; i < `RING_MEMBERS; i++)
		begin
			if (addr == i + 1)
				m = i;
		end
		return m;
	endfunction

	task automatic note_error();
		error_count++;
		trans_bad = 1'b1;
	endtask

	task automatic check_delivery(input int m);
		if (exp_sender.size() == 0 || exp_rx[0] != m || rx_seen)
		begin
			$display("member %0d delivered a message that was not expected", m);
			note_error();
		end
		else
		begin
			rx_seen = 1'b1;
			if (rx[m].msg !== exp_msg[0])
			begin
				$display("ERROR rx[%0d].msg expected %h got %h", m, exp_msg[0], rx[m].msg);
				note_error();
			end
		end
	endtask

	task automatic check_ack(input int m);
		bit last;
		if (!tx[m].req)
		begin
			$display("member %0d raised tx_ack without a pending request", m);
			note_error();
		end
		if (exp_sender.size() == 0 || exp_sender[0] != m)
		begin
			$display("member %0d acknowledged a message out of order", m);
			note_error();
		end
		else
		begin
			if (exp_rx[0] >= 0 && !rx_seen)
			begin
				$display("message from member %0d was acknowledged but never reached member %0d",
					m, exp_rx[0]);
				note_error();
			end
			last = exp_last[0];
			void'(exp_sender.pop_front());
			void'(exp_rx.pop_front());
			void'(exp_msg.pop_front());
			void'(exp_last.pop_front());
			rx_seen = 1'b0;
			if (last)
			begin
				if (trans_bad)
				begin
					fail_count++;
					$display("transaction %0d failed", trans_idx);
				end
				else
				begin
					pass_count++;
					$display("transaction %0d passed", trans_idx);
				end
				trans_idx++;
				trans_bad = 1'b0;
			end
			if (exp_sender.size() == 0)
				done = 1'b1;
		end
	endtask

	initial
	begin
		int t;
		ring_msg_t msg;
		done = 1'b0;
		pass_count = 0;
		fail_count = 0;
		error_count = 0;
		rx_seen = 1'b0;
		trans_bad = 1'b0;
		trans_idx = 0;
		$readmemh("testbench/ring_bus_input.txt", words);
		t = 0;
		while (t < MAX_LINES && !$isunknown(words[t*COLS]) && words[t*COLS] != 8'h00)
		begin
			// member 0 wins arbitration, so its message goes first
			for (int s = 0; s < `RING_MEMBERS; s++)
			begin
				if (words[t*COLS][s])
				begin
					msg.addr = words[t*COLS+1+2*s][`RING_ADDR_BITS-1:0];
					msg.data = words[t*COLS+2+2*s];
					exp_sender.push_back(s);
					exp_rx.push_back(member_for(msg.addr));
					exp_msg.push_back(msg);
					exp_last.push_back(s == `RING_MEMBERS - 1 || words[t*COLS][1] == 1'b0);
				end
			end
			t++;
		end
	end

	always @(negedge CLK)
	begin
		if (RESET)
		begin
			for (int m = 0; m < `RING_MEMBERS; m++)
			begin
				if (rx[m].valid)
					check_delivery(m);
			end
			for (int m = 0; m < `RING_MEMBERS; m++)
			begin
				if (tx_ack[m] && !ack_q[m])
					check_ack(m);
				else if (!tx_ack[m] && ack_q[m] && tx[m].req)
				begin
					$display("member %0d dropped tx_ack while req was still high", m);
					error_count++;
				end
			end
		end
		for (int m = 0; m < `RING_MEMBERS; m++)
			ack_q[m] = tx_ack[m];
	end

endmodule

`default_nettype wire

/* testbench/ring_bus_tb.sv */
`default_nettype none

`include "ring_bus_config.svh"

module ring_bus_tb
	import ring_bus_msg_pkg::*;
();

	localparam int MAX_LINES = 16;
	localparam int COLS = 6;

	logic CLK;
	logic RESET;
	ring_tx_t tx [`RING_MEMBERS];
	logic tx_ack [`RING_MEMBERS];
	ring_rx_t rx [`RING_MEMBERS];
	logic done;
	int pass_count;
	int fail_count;
	int error_count;
	logic [7:0] words [0:MAX_LINES*COLS-1];
	int cycles;
	int cycle_limit;

	ring_bus_top ring_bus_top_inst
	(
		.CLK(CLK),
		.RESET(RESET),
		.tx(tx),
		.tx_ack(tx_ack),
		.rx(rx)
	);

	ring_bus_checker checker_inst
	(
		.CLK(CLK),
		.RESET(RESET),
		.tx(tx),
		.tx_ack(tx_ack),
		.rx(rx),
		.done(done),
		.pass_count(pass_count),
		.fail_count(fail_count),
		.error_count(error_count)
	);

	always #5 CLK = ~CLK;

	always @(negedge CLK)
	begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("timeout, no acknowledge within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// rest of the four-phase handshake for one sender
	task automatic finish_handshake(input int s);
		wait (tx_ack[s] === 1'b1);
		@(posedge CLK);
		#1;
		tx[s].req = 1'b0;
		wait (tx_ack[s] === 1'b0);
	endtask

	initial
	begin
		int lines;
		int msgs;
		int base;
		CLK = 1'b0;
		RESET = 1'b0;
		cycles = 0;
		for (int i = 0; i < `RING_MEMBERS; i++)
			tx[i] = '0;
		$readmemh("testbench/ring_bus_input.txt", words);

		// about 120 cycles per bus message, plus reset, delays and settling
		lines = 0;
		msgs = 0;
		cycle_limit = 10 + 20;
		while (lines < MAX_LINES && !$isunknown(words[lines*COLS])
			&& words[lines*COLS] != 8'h00)
		begin
			msgs += words[lines*COLS][0] + words[lines*COLS][1];
			cycle_limit += words[lines*COLS+5];
			lines++;
		end
		cycle_limit += 200 * msgs;

		repeat (10) @(posedge CLK);
		#1;
		RESET = 1'b1;

		for (int row = 0; row < lines; row++)
		begin
			base = row * COLS;
			repeat (words[base+5]) @(posedge CLK);
			@(posedge CLK);
			#1;
			for (int s = 0; s < `RING_MEMBERS; s++)
			begin
				if (words[base][s])
				begin
					tx[s].msg.addr = words[base+1+2*s][`RING_ADDR_BITS-1:0];
					tx[s].msg.data = words[base+2+2*s];
					tx[s].req = 1'b1;
				end
			end
			fork
				if (words[base][0]) finish_handshake(0);
				if (words[base][1]) finish_handshake(1);
			join
		end

		wait (done === 1'b1);
		// catch late or repeated deliveries
		repeat (20) @(posedge CLK);
		$display("transactions passed %0d failed %0d, errors %0d",
			pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0 && pass_count == lines)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* ring_bus.f */
+incdir+src
src/ring_bus_msg_pkg.sv
src/ring_bus_line_pkg.sv
src/ring_bus_ctrl.sv
src/ring_bus_member.sv
src/ring_bus_top.sv
testbench/ring_bus_checker.sv
testbench/ring_bus_tb.sv

/* testbench/ring_bus_input.txt */
// senders(bit0 member 0, bit1 member 1) addr0 data0 addr1 data1 delay, all hex
// a line with senders 0 ends the list
01 2 a5 0 00 04
02 0 00 1 3c 04
01 7 5a 0 00 04
02 0 00 7 c3 02
03 2 11 1 22 04
01 2 ff 0 00 00
02 0 00 1 ff 00
01 2 00 0 00 00
02 0 00 1 00 00
00 0 00 0 00 00
